//--- audio_frame_energy.f
verilog/frame_pkg.sv
verilog/sample_fifo.sv
verilog/window_buffer.sv
verilog/frame_reader.sv
verilog/frame_energy.sv
verilog/audio_frame_energy.sv
verif/audio_frame_energy_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
verilator --binary --timing --assert -Wno-fatal \
    --top-module audio_frame_energy_tb -f audio_frame_energy.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vaudio_frame_energy_tb > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

//--- verif/audio_frame_energy_tb.sv
`timescale 1ns/1ps

module audio_frame_energy_tb;

    localparam int WAIT_LIMIT = 4 * frame_pkg::FRAME_SIZE;

    logic                              clk;
    logic                              rst_n;
    logic                              sample_valid_i;
    logic [frame_pkg::SAMPLE_W-1:0]    sample_i;
    logic                              credit_o;
    logic [frame_pkg::ENERGY_W-1:0]    energy_o;
    logic                              energy_valid_o;
    logic [frame_pkg::FRAME_IDX_W-1:0] frame_idx_o;

    logic [31:0] lfsr;
    int          sent;
    int          returned;
    int          next_frame;

    // every sample sent since the last reset, oldest first
    logic signed [frame_pkg::SAMPLE_W-1:0] stream [$];
    longint                                got_energy [$];
    int                                    got_idx [$];

    audio_frame_energy dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .credit_o       (credit_o),
        .energy_o       (energy_o),
        .energy_valid_o (energy_valid_o),
        .frame_idx_o    (frame_idx_o)
    );

    always #4 clk = ~clk;

    // ========================================
    // failure reporting and random bits
    // ========================================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string test, input longint exp, input longint act);
        abort_run($sformatf("error: %s expected %0d actual %0d", test, exp, act));
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        repeat (n) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // ========================================
    // credit tracking and result capture
    // ========================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            returned = 0;
            got_energy.delete();
            got_idx.delete();
        end else begin
            if (credit_o) begin
                returned++;
                assert (returned <= sent)
                    else abort_run("credit returned with no sample outstanding");
            end
            if (energy_valid_o) begin
                got_energy.push_back(longint'(energy_o));
                got_idx.push_back(int'(frame_idx_o));
            end
        end
    end

    // called on a falling edge, returns on the next one
    task automatic send_sample(input logic [frame_pkg::SAMPLE_W-1:0] value);
        int waited;
        waited = 0;
        while (sent - returned >= frame_pkg::FIFO_DEPTH) begin
            @(negedge clk);
            waited++;
            assert (waited < WAIT_LIMIT) else abort_run("sender starved of credits");
        end
        sample_valid_i = 1'b1;
        sample_i       = value;
        sent++;
        stream.push_back(value);
        @(negedge clk);
        sample_valid_i = 1'b0;
    endtask

    task automatic send_random(input int count, input bit with_gaps);
        logic [31:0] bits;
        repeat (count) begin
            if (with_gaps) begin
                take_bits(2, bits);
                repeat (bits[1:0]) @(negedge clk);
            end
            take_bits(frame_pkg::SAMPLE_W, bits);
            send_sample(bits[frame_pkg::SAMPLE_W-1:0]);
        end
    endtask

    task automatic apply_reset();
        sample_valid_i = 1'b0;
        rst_n          = 1'b0;
        sent           = 0;
        next_frame     = 0;
        stream.delete();
        repeat (4) begin
            @(negedge clk);
            assert (!credit_o && !energy_valid_o) else abort_run("outputs active in reset");
        end
        rst_n = 1'b1;
    endtask

    // sum of squares over frame k of the sample stream
    function automatic longint frame_sum(input int k);
        longint acc;
        longint v;
        int     i;
        acc = 0;
        for (i = 0; i < frame_pkg::FRAME_SIZE; i++) begin
            v = longint'(stream[k * frame_pkg::HOP_SIZE + i]);
            acc += v * v;
        end
        return acc;
    endfunction

    // waits for every frame the stream completes and checks each one
    task automatic check_frames(input string test);
        int     total;
        int     waited;
        longint act_e;
        int     act_i;
        total = 0;
        if (stream.size() >= frame_pkg::FRAME_SIZE) begin
            total = (stream.size() - frame_pkg::FRAME_SIZE) / frame_pkg::HOP_SIZE + 1;
        end
        waited = 0;
        while (got_energy.size() < total - next_frame) begin
            @(negedge clk);
            waited++;
            assert (waited < WAIT_LIMIT) else abort_run({test, " timed out waiting for energy"});
        end
        while (got_energy.size() > 0) begin
            act_e = got_energy.pop_front();
            act_i = got_idx.pop_front();
            assert (act_i == next_frame) else report_mismatch(test, next_frame, act_i);
            assert (act_e == frame_sum(next_frame))
                else report_mismatch(test, frame_sum(next_frame), act_e);
            next_frame++;
        end
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic test_reset_state();
        apply_reset();
        repeat (4) begin
            @(negedge clk);
            assert (!credit_o && !energy_valid_o) else abort_run("outputs active after reset");
        end
        send_random(frame_pkg::FRAME_SIZE - 1, 1'b0);
        repeat (2 * frame_pkg::FRAME_SIZE) @(negedge clk);
        assert (got_energy.size() == 0) else abort_run("energy before a full frame was sent");
    endtask

    task automatic test_single_frame();
        apply_reset();
        send_random(frame_pkg::FRAME_SIZE, 1'b0);
        check_frames("single_frame");
        assert (next_frame == 1) else report_mismatch("single_frame", 1, next_frame);
    endtask

    // three hops on top of frame 0 complete frames 1 to 3
    task automatic test_overlap();
        send_random(3 * frame_pkg::HOP_SIZE, 1'b0);
        check_frames("overlap");
        assert (next_frame == 4) else report_mismatch("overlap", 4, next_frame);
    endtask

    task automatic test_credit_flow();
        int waited;
        send_random(2 * frame_pkg::HOP_SIZE, 1'b1);
        check_frames("credit_gaps");
        send_random(2 * frame_pkg::HOP_SIZE, 1'b0);
        check_frames("credit_burst");
        // FIFO drains into the next hop, so every credit comes back
        waited = 0;
        while (returned != sent) begin
            @(negedge clk);
            waited++;
            assert (waited < WAIT_LIMIT) else abort_run("credits not returned after the burst");
        end
    endtask

    // last frame ends up entirely full scale
    task automatic test_full_scale();
        int i;
        for (i = 0; i < 3 * frame_pkg::HOP_SIZE; i++) begin
            send_sample(i[0] ? 16'sh7fff : 16'sh8000);
        end
        check_frames("full_scale");
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        sample_valid_i = 1'b0;
        sample_i       = '0;
        lfsr           = 32'hdfa6;
        test_reset_state();
        test_single_frame();
        test_overlap();
        test_credit_flow();
        test_full_scale();
        repeat (20) @(negedge clk);
        if (got_energy.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("unexpected energy results after the last test");
        end
    end

endmodule

//--- verilog/audio_frame_energy.sv
`timescale 1ns/1ps

module audio_frame_energy (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              sample_valid_i,
    input  logic [frame_pkg::SAMPLE_W-1:0]    sample_i,
    output logic                              credit_o,
    output logic [frame_pkg::ENERGY_W-1:0]    energy_o,
    output logic                              energy_valid_o,
    output logic [frame_pkg::FRAME_IDX_W-1:0] frame_idx_o
);

    // FIFO to window buffer
    logic                           fifo_rd_en;
    logic [frame_pkg::SAMPLE_W-1:0] fifo_data;
    logic                           fifo_empty;

    // window buffer to reader
    logic                           rd_en;
    logic                           rd_valid;
    logic [frame_pkg::SAMPLE_W-1:0] rd_data;
    logic                           frame_start;
    logic                           move;

    // reader to accumulator
    logic                           sample_en;
    logic [frame_pkg::SAMPLE_W-1:0] frame_sample;
    logic                           last;

    sample_fifo fifo_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_valid_i (sample_valid_i),
        .sample_i       (sample_i),
        .rd_en_i        (fifo_rd_en),
        .rd_data_o      (fifo_data),
        .empty_o        (fifo_empty),
        .credit_o       (credit_o)
    );

    window_buffer window_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .move_i        (move),
        .fifo_data_i   (fifo_data),
        .fifo_empty_i  (fifo_empty),
        .rd_en_i       (rd_en),
        .fifo_rd_en_o  (fifo_rd_en),
        .rd_data_o     (rd_data),
        .rd_valid_o    (rd_valid),
        .frame_start_o (frame_start)
    );

    frame_reader reader_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .rd_valid_i    (rd_valid),
        .rd_data_i     (rd_data),
        .frame_start_i (frame_start),
        .rd_en_o       (rd_en),
        .sample_en_o   (sample_en),
        .sample_o      (frame_sample),
        .last_o        (last),
        .move_o        (move)
    );

    frame_energy energy_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .sample_en_i    (sample_en),
        .sample_i       (frame_sample),
        .last_i         (last),
        .energy_o       (energy_o),
        .energy_valid_o (energy_valid_o),
        .frame_idx_o    (frame_idx_o)
    );

endmodule

//--- verilog/frame_energy.sv
`timescale 1ns/1ps

module frame_energy (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              sample_en_i,
    input  logic [frame_pkg::SAMPLE_W-1:0]    sample_i,
    input  logic                              last_i,
    output logic [frame_pkg::ENERGY_W-1:0]    energy_o,
    output logic                              energy_valid_o,
    output logic [frame_pkg::FRAME_IDX_W-1:0] frame_idx_o
);

    logic signed [2*frame_pkg::SAMPLE_W-1:0] sq;
    logic [frame_pkg::ENERGY_W-1:0]          sq_ext;
    logic [frame_pkg::ENERGY_W-1:0]          acc;
    logic [frame_pkg::ENERGY_W-1:0]          sum;
    logic [frame_pkg::FRAME_IDX_W-1:0]       idx;

    // signed square, never negative
    assign sq     = $signed(sample_i) * $signed(sample_i);
    assign sq_ext = {{(frame_pkg::ENERGY_W - 2 * frame_pkg::SAMPLE_W){1'b0}}, sq};
    assign sum    = acc + sq_ext;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc            <= '0;
            idx            <= '0;
            energy_valid_o <= 1'b0;
        end else begin
            energy_valid_o <= sample_en_i && last_i;
            if (sample_en_i) begin
                if (last_i) begin
                    acc <= '0;
                    idx <= idx + 1'b1;
                end else begin
                    acc <= sum;
                end
            end
        end
    end

    // result includes the last sample's square
    always_ff @(posedge clk) begin
        if (sample_en_i && last_i) begin
            energy_o    <= sum;
            frame_idx_o <= idx;
        end
    end

endmodule

//--- verilog/frame_pkg.sv
package frame_pkg;

    // ========================================
    // sample and frame geometry
    // ========================================
    localparam int SAMPLE_W    = 16;
    localparam int FRAME_SIZE  = 306;
    localparam int HOP_SIZE    = 123;

    // sample FIFO depth, also the sender's initial credits
    localparam int FIFO_DEPTH  = 8;

    // 306 full-scale squares need 39 bits
    localparam int ENERGY_W    = 48;
    localparam int FRAME_IDX_W = 16;

    // derived widths
    localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
    localparam int FRAME_AW    = $clog2(FRAME_SIZE);
    localparam int FRAME_CW    = $clog2(FRAME_SIZE + 1);

    // ========================================
    // state encodings
    // ========================================
    typedef enum logic [2:0] {
        WIN_START,
        WIN_IDLE,
        WIN_MOVE,
        WIN_REQUEST,
        WIN_FILL
    } win_state_t;

    typedef enum logic [1:0] {
        RDR_WAIT,
        RDR_READ,
        RDR_MOVE
    } rdr_state_t;

endpackage

//--- verilog/frame_reader.sv
`timescale 1ns/1ps

module frame_reader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           rd_valid_i,
    input  logic [frame_pkg::SAMPLE_W-1:0] rd_data_i,
    input  logic                           frame_start_i,
    output logic                           rd_en_o,
    output logic                           sample_en_o,
    output logic [frame_pkg::SAMPLE_W-1:0] sample_o,
    output logic                           last_o,
    output logic                           move_o
);

    frame_pkg::rdr_state_t state;

    logic [frame_pkg::FRAME_CW-1:0] cnt;
    logic                           at_last;

    // one sample per cycle whenever the buffer offers one
    assign rd_en_o = (state == frame_pkg::RDR_READ) && rd_valid_i;
    assign at_last = (cnt == (frame_pkg::FRAME_CW)'(frame_pkg::FRAME_SIZE - 1));

    assign sample_en_o = rd_en_o;
    assign sample_o    = rd_data_i;
    assign last_o      = rd_en_o && at_last;
    assign move_o      = (state == frame_pkg::RDR_MOVE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= frame_pkg::RDR_WAIT;
            cnt   <= '0;
        end else begin
            case (state)
                frame_pkg::RDR_WAIT: begin
                    if (frame_start_i) begin
                        cnt   <= '0;
                        state <= frame_pkg::RDR_READ;
                    end
                end
                frame_pkg::RDR_READ: begin
                    if (rd_en_o) begin
                        cnt <= cnt + 1'b1;
                        if (at_last) begin
                            state <= frame_pkg::RDR_MOVE;
                        end
                    end
                end
                frame_pkg::RDR_MOVE: begin
                    // single move pulse, then wait for the refill
                    state <= frame_pkg::RDR_WAIT;
                end
                default: begin
                    state <= frame_pkg::RDR_WAIT;
                end
            endcase
        end
    end

    // whole frame consumed, buffer has nothing left to offer
    assert_move_not_reading: assert property (
        @(posedge clk) disable iff (!rst_n)
        move_o |-> !rd_valid_i
    );

endmodule

//--- verilog/sample_fifo.sv
`timescale 1ns/1ps

module sample_fifo (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           sample_valid_i,
    input  logic [frame_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                           rd_en_i,
    output logic [frame_pkg::SAMPLE_W-1:0] rd_data_o,
    output logic                           empty_o,
    output logic                           credit_o
);

    logic [frame_pkg::SAMPLE_W-1:0] mem [frame_pkg::FIFO_DEPTH];
    logic [frame_pkg::FIFO_AW-1:0]  wr_ptr;
    logic [frame_pkg::FIFO_AW-1:0]  rd_ptr;
    logic [frame_pkg::FIFO_AW:0]    count;
    logic                           push;
    logic                           pop;
    logic                           full;

    // sender only pushes while holding a credit
    assign push    = sample_valid_i;
    assign pop     = rd_en_i && !empty_o;
    assign empty_o = (count == '0);
    assign full    = (count == (frame_pkg::FIFO_AW + 1)'(frame_pkg::FIFO_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per popped entry
            credit_o <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= sample_i;
        end
    end

    // read data lands one cycle after the pop
    always_ff @(posedge clk) begin
        if (pop) begin
            rd_data_o <= mem[rd_ptr];
        end
    end

    // ========================================
    // flow control checks
    // ========================================
    // credits must keep the sender from overrunning the store
    assert_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (!full || pop)
    );

    // window buffer only requests when data is there
    assert_no_underflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en_i |-> !empty_o
    );

endmodule

//--- verilog/window_buffer.sv
`timescale 1ns/1ps

module window_buffer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           move_i,
    input  logic [frame_pkg::SAMPLE_W-1:0] fifo_data_i,
    input  logic                           fifo_empty_i,
    input  logic                           rd_en_i,
    output logic                           fifo_rd_en_o,
    output logic [frame_pkg::SAMPLE_W-1:0] rd_data_o,
    output logic                           rd_valid_o,
    output logic                           frame_start_o
);

    logic [frame_pkg::SAMPLE_W-1:0] store [frame_pkg::FRAME_SIZE];

    frame_pkg::win_state_t state;
    frame_pkg::win_state_t state_nxt;

    logic [frame_pkg::FRAME_AW-1:0] wr_ptr;
    logic [frame_pkg::FRAME_AW-1:0] base;
    logic [frame_pkg::FRAME_AW-1:0] rd_ptr;
    logic [frame_pkg::FRAME_AW:0]   base_hop;
    logic [frame_pkg::FRAME_AW:0]   rd_sum;
    logic [frame_pkg::FRAME_CW-1:0] req_left;
    logic [frame_pkg::FRAME_CW-1:0] avail;
    logic [frame_pkg::FRAME_CW-1:0] rd_off;
    logic                           rd_fire;

    // ========================================
    // fill sequencing
    // ========================================
    assign fifo_rd_en_o = ((state == frame_pkg::WIN_REQUEST) || (state == frame_pkg::WIN_FILL))
                          && (req_left != '0) && !fifo_empty_i;

    assign frame_start_o = (state == frame_pkg::WIN_START) || (state == frame_pkg::WIN_MOVE);

    always_comb begin
        state_nxt = state;
        unique case (state)
            frame_pkg::WIN_START: begin
                state_nxt = frame_pkg::WIN_REQUEST;
            end
            frame_pkg::WIN_IDLE: begin
                if (move_i) begin
                    state_nxt = frame_pkg::WIN_MOVE;
                end
            end
            frame_pkg::WIN_MOVE: begin
                state_nxt = frame_pkg::WIN_REQUEST;
            end
            frame_pkg::WIN_REQUEST: begin
                if (fifo_rd_en_o) begin
                    state_nxt = frame_pkg::WIN_FILL;
                end
            end
            frame_pkg::WIN_FILL: begin
                // data from last cycle's pop is written here
                if (fifo_rd_en_o) begin
                    state_nxt = frame_pkg::WIN_FILL;
                end else if (req_left != '0) begin
                    state_nxt = frame_pkg::WIN_REQUEST;
                end else begin
                    state_nxt = frame_pkg::WIN_IDLE;
                end
            end
            default: begin
                state_nxt = frame_pkg::WIN_START;
            end
        endcase
    end

    // frame base slides one hop, wrapping at the frame size
    assign base_hop = {1'b0, base} + (frame_pkg::FRAME_AW + 1)'(frame_pkg::HOP_SIZE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= frame_pkg::WIN_START;
            wr_ptr   <= '0;
            base     <= '0;
            req_left <= '0;
            avail    <= '0;
            rd_off   <= '0;
        end else begin
            state <= state_nxt;
            if (fifo_rd_en_o) begin
                req_left <= req_left - 1'b1;
            end
            if (state == frame_pkg::WIN_FILL) begin
                if (wr_ptr == (frame_pkg::FRAME_AW)'(frame_pkg::FRAME_SIZE - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            case (state)
                frame_pkg::WIN_START: begin
                    base     <= '0;
                    req_left <= (frame_pkg::FRAME_CW)'(frame_pkg::FRAME_SIZE);
                    avail    <= '0;
                    rd_off   <= '0;
                end
                frame_pkg::WIN_MOVE: begin
                    if (base_hop >= (frame_pkg::FRAME_AW + 1)'(frame_pkg::FRAME_SIZE)) begin
                        base <= (frame_pkg::FRAME_AW)'(base_hop - frame_pkg::FRAME_SIZE);
                    end else begin
                        base <= base_hop[frame_pkg::FRAME_AW-1:0];
                    end
                    req_left <= (frame_pkg::FRAME_CW)'(frame_pkg::HOP_SIZE);
                    // overlap part of the old frame stays readable
                    avail    <= (frame_pkg::FRAME_CW)'(frame_pkg::FRAME_SIZE
                                                       - frame_pkg::HOP_SIZE);
                    rd_off   <= '0;
                end
                default: begin
                    if (state == frame_pkg::WIN_FILL) begin
                        avail <= avail + 1'b1;
                    end
                    if (rd_fire) begin
                        rd_off <= rd_off + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == frame_pkg::WIN_FILL) begin
            store[wr_ptr] <= fifo_data_i;
        end
    end

    // ========================================
    // read side
    // ========================================
    // read position trails the written part of the frame
    assign rd_valid_o = (rd_off < avail);
    assign rd_fire    = rd_en_i && rd_valid_o;

    assign rd_sum = {1'b0, base} + (frame_pkg::FRAME_AW + 1)'(rd_off);
    assign rd_ptr = (rd_sum >= (frame_pkg::FRAME_AW + 1)'(frame_pkg::FRAME_SIZE))
                    ? (frame_pkg::FRAME_AW)'(rd_sum - frame_pkg::FRAME_SIZE)
                    : rd_sum[frame_pkg::FRAME_AW-1:0];

    assign rd_data_o = store[rd_ptr];

    assert_rd_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en_i |-> rd_valid_o
    );

    // reader only moves once the fill has finished
    assert_move_in_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        move_i |-> (state == frame_pkg::WIN_IDLE)
    );

endmodule
